//--- aes_state_pkg.sv
// Data-path types and block geometry for the AES-256 encryption core.
// The state matrix follows FIPS-197 column order with byte 0 in the top
// bits, so a 128-bit block maps onto aes_state_t without reordering.
// Blocks refer to these names as aes_state_pkg::name.
package aes_state_pkg;

    // Block geometry
    localparam int BYTE_W  = 8;
    localparam int N_BYTES = 16;
    localparam int BLOCK_W = N_BYTES * BYTE_W;

    // Low byte of the field polynomial x^8 + x^4 + x^3 + x + 1
    localparam logic [BYTE_W-1:0] GF_POLY = 8'h1b;

    typedef logic [BYTE_W-1:0] aes_byte_t;

    // One column, row 0 in the top byte
    typedef struct packed {
        aes_byte_t b0;
        aes_byte_t b1;
        aes_byte_t b2;
        aes_byte_t b3;
    } aes_col_t;

    // Full state, column 0 in the top word
    typedef struct packed {
        aes_col_t c0;
        aes_col_t c1;
        aes_col_t c2;
        aes_col_t c3;
    } aes_state_t;

endpackage

//--- aes_ctrl_pkg.sv
// Control definitions for the AES-256 round sequencer.
// Holds the round count, the FSM encoding and the strobe bundle that
// the controller sends to every data-path block.
package aes_ctrl_pkg;

    localparam int NUM_ROUNDS = 14;
    localparam int KEY_ADDR_W = 4;

    // Round FSM states
    typedef enum logic [3:0] {
        st_idle,
        st_add_key,
        st_load,
        st_sub,
        st_sub_wait,
        st_shift,
        st_mix,
        st_hold,
        st_end_round,
        st_finish
    } aes_fsm_t;

    // Strobes to the data path, loop_sel and last_round are levels
    typedef struct packed {
        logic ark_en;
        logic loop_sel;
        logic ser_load;
        logic sub_req;
        logic shift_en;
        logic mix_en;
        logic hold_en;
        logic last_round;
    } aes_ctl_t;

endpackage

//--- aes_sbox_rom.sv
// Forward AES S-box as a registered lookup table.
// One byte goes in per cycle and its substitute comes out on the next.
// This single ROM serves all 16 state bytes in turn during SubBytes.
`timescale 1ns/1ps

module aes_sbox_rom (
    input  logic                    clk,
    input  logic                    resetn,
    input  aes_state_pkg::aes_byte_t addr,
    output aes_state_pkg::aes_byte_t sbox_out
);

    // Row n of the table holds entries 16n to 16n+15, entry 0 first
    localparam logic [0:255][7:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // Registered lookup
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            sbox_out <= '0;
        end
        else
        begin
            sbox_out <= SBOX[addr];
        end
    end

endmodule

//--- aes_byte_serializer.sv
// Parallel-to-serial stage in front of the S-box ROM.
// Takes the key-added state on ser_load and hands out one byte per
// cycle, byte 0 first, for as long as sub_req is high.
`timescale 1ns/1ps

module aes_byte_serializer (
    input  logic                     clk,
    input  logic                     resetn,
    input  aes_ctrl_pkg::aes_ctl_t   ctl,
    input  aes_state_pkg::aes_state_t state_in,
    output aes_state_pkg::aes_byte_t  byte_out
);

    aes_state_pkg::aes_state_t shift_q;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            shift_q <= '0;
        end
        else if (ctl.ser_load)
        begin
            shift_q <= state_in;
        end
        else if (ctl.sub_req)
        begin
            // Next byte moves up into the output slot
            shift_q <= aes_state_pkg::aes_state_t'(shift_q << aes_state_pkg::BYTE_W);
        end
    end

    // Top byte is the one currently being substituted
    assign byte_out = shift_q.c0.b0;

endmodule

//--- aes_shift_rows.sv
// Collects the 16 substituted bytes from the S-box ROM and applies
// ShiftRows when shift_en arrives. Writes trail sub_req by one cycle
// to match the ROM latency.
`timescale 1ns/1ps

module aes_shift_rows (
    input  logic                     clk,
    input  logic                     resetn,
    input  aes_ctrl_pkg::aes_ctl_t   ctl,
    input  aes_state_pkg::aes_byte_t  byte_in,
    output aes_state_pkg::aes_state_t state_out
);

    aes_state_pkg::aes_state_t collect_q;
    logic                      wr_en_q;

    // ROM data lands one cycle after each request
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_en_q <= 1'b0;
        end
        else
        begin
            wr_en_q <= ctl.sub_req;
        end
    end

    always_ff @(posedge clk)
    begin
        // Bytes enter at the bottom, byte 0 ends up on top
        if (wr_en_q)
        begin
            collect_q <= aes_state_pkg::aes_state_t'((collect_q << aes_state_pkg::BYTE_W)
                                                      | byte_in);
        end
        // Row r rotates left by r columns
        if (ctl.shift_en)
        begin
            state_out.c0 <= '{collect_q.c0.b0, collect_q.c1.b1, collect_q.c2.b2, collect_q.c3.b3};
            state_out.c1 <= '{collect_q.c1.b0, collect_q.c2.b1, collect_q.c3.b2, collect_q.c0.b3};
            state_out.c2 <= '{collect_q.c2.b0, collect_q.c3.b1, collect_q.c0.b2, collect_q.c1.b3};
            state_out.c3 <= '{collect_q.c3.b0, collect_q.c0.b1, collect_q.c1.b2, collect_q.c2.b3};
        end
    end

endmodule

//--- aes_mix_columns.sv
// MixColumns over the four state columns, registered on mix_en.
// Multiplication by 2 and 3 in GF(2^8) is built from xtime.
`timescale 1ns/1ps

module aes_mix_columns (
    input  logic                     clk,
    input  logic                     resetn,
    input  aes_ctrl_pkg::aes_ctl_t   ctl,
    input  aes_state_pkg::aes_state_t state_in,
    output aes_state_pkg::aes_state_t state_out
);

    // Multiply by x, reduce when the top bit falls out
    function automatic aes_state_pkg::aes_byte_t xtime(input aes_state_pkg::aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? aes_state_pkg::GF_POLY : 8'h00);
    endfunction

    // Fixed matrix rows 2 3 1 1, rotated per output byte
    function automatic aes_state_pkg::aes_col_t mix_col(input aes_state_pkg::aes_col_t a);
        aes_state_pkg::aes_col_t r;
        r.b0 = xtime(a.b0) ^ xtime(a.b1) ^ a.b1 ^ a.b2 ^ a.b3;
        r.b1 = a.b0 ^ xtime(a.b1) ^ xtime(a.b2) ^ a.b2 ^ a.b3;
        r.b2 = a.b0 ^ a.b1 ^ xtime(a.b2) ^ xtime(a.b3) ^ a.b3;
        r.b3 = xtime(a.b0) ^ a.b0 ^ a.b1 ^ a.b2 ^ xtime(a.b3);
        return r;
    endfunction

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_out <= '0;
        end
        else if (ctl.mix_en)
        begin
            state_out.c0 <= mix_col(state_in.c0);
            state_out.c1 <= mix_col(state_in.c1);
            state_out.c2 <= mix_col(state_in.c2);
            state_out.c3 <= mix_col(state_in.c3);
        end
    end

endmodule

//--- aes_add_round_key.sv
// AddRoundKey stage with the end-of-round state register.
// The hold register keeps the finished round, taking the ShiftRows
// result in the last round where MixColumns is skipped.
// loop_sel picks the external block for round 0, the hold register after.
`timescale 1ns/1ps

module aes_add_round_key (
    input  logic                     clk,
    input  logic                     resetn,
    input  aes_ctrl_pkg::aes_ctl_t   ctl,
    input  aes_state_pkg::aes_state_t block_in,
    input  aes_state_pkg::aes_state_t shifted,
    input  aes_state_pkg::aes_state_t mixed,
    input  aes_state_pkg::aes_state_t round_key,
    output aes_state_pkg::aes_state_t state_out
);

    aes_state_pkg::aes_state_t hold_q;
    aes_state_pkg::aes_state_t ark_in;

    // End-of-round capture
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            hold_q <= '0;
        end
        else if (ctl.hold_en)
        begin
            hold_q <= ctl.last_round ? shifted : mixed;
        end
    end

    // Plaintext on the first pass, looped state otherwise
    assign ark_in = ctl.loop_sel ? hold_q : block_in;

    // Key XOR, also the ciphertext register after the final pass
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_out <= '0;
        end
        else if (ctl.ark_en)
        begin
            state_out <= ark_in ^ round_key;
        end
    end

endmodule

//--- aes_round_ctrl.sv
// Round sequencer for the iterative AES-256 core.
// Steps each round through key add, byte-serial SubBytes, ShiftRows,
// MixColumns and hold, and drives the external key address.
// All strobes are registered decodes of the next state.
`timescale 1ns/1ps

module aes_round_ctrl (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                start,
    output aes_ctrl_pkg::aes_ctl_t              ctl,
    output logic [aes_ctrl_pkg::KEY_ADDR_W-1:0] key_addr,
    output logic                                done
);

    aes_ctrl_pkg::aes_fsm_t                      state_q;
    aes_ctrl_pkg::aes_fsm_t                      state_next;
    logic [$clog2(aes_state_pkg::N_BYTES)-1:0]   byte_cnt;
    logic [aes_ctrl_pkg::KEY_ADDR_W-1:0]         round;

    always_comb
    begin
        state_next = state_q;
        case (state_q)
            aes_ctrl_pkg::st_idle:
                if (start)
                    state_next = aes_ctrl_pkg::st_add_key;
            // Key add after round 14 is the final one
            aes_ctrl_pkg::st_add_key:
                state_next = (round == aes_ctrl_pkg::NUM_ROUNDS) ? aes_ctrl_pkg::st_finish
                                                                 : aes_ctrl_pkg::st_load;
            aes_ctrl_pkg::st_load:
                state_next = aes_ctrl_pkg::st_sub;
            // One ROM request per byte
            aes_ctrl_pkg::st_sub:
                if (byte_cnt == aes_state_pkg::N_BYTES - 1)
                    state_next = aes_ctrl_pkg::st_sub_wait;
            aes_ctrl_pkg::st_sub_wait:
                state_next = aes_ctrl_pkg::st_shift;
            // No MixColumns in the last round
            aes_ctrl_pkg::st_shift:
                state_next = (round == aes_ctrl_pkg::NUM_ROUNDS) ? aes_ctrl_pkg::st_hold
                                                                 : aes_ctrl_pkg::st_mix;
            aes_ctrl_pkg::st_mix:
                state_next = aes_ctrl_pkg::st_hold;
            aes_ctrl_pkg::st_hold:
                state_next = aes_ctrl_pkg::st_end_round;
            aes_ctrl_pkg::st_end_round:
                state_next = aes_ctrl_pkg::st_add_key;
            default:
                state_next = aes_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q  <= aes_ctrl_pkg::st_idle;
            byte_cnt <= '0;
            round    <= '0;
            key_addr <= '0;
            ctl      <= '0;
            done     <= 1'b0;
        end
        else
        begin
            state_q  <= state_next;
            byte_cnt <= (state_q == aes_ctrl_pkg::st_sub) ? byte_cnt + 1'b1 : '0;
            done     <= (state_q == aes_ctrl_pkg::st_finish);
            // New round starts at load, key moves ahead at end of round
            if (state_next == aes_ctrl_pkg::st_idle)
            begin
                round          <= '0;
                key_addr       <= '0;
                ctl.loop_sel   <= 1'b0;
                ctl.last_round <= 1'b0;
            end
            else if (state_next == aes_ctrl_pkg::st_load)
            begin
                round          <= round + 1'b1;
                ctl.loop_sel   <= 1'b1;
                ctl.last_round <= (round == aes_ctrl_pkg::NUM_ROUNDS - 1);
            end
            else if (state_next == aes_ctrl_pkg::st_end_round)
            begin
                key_addr <= key_addr + 1'b1;
            end
            // One-cycle strobes, high during their own state
            ctl.ark_en   <= (state_next == aes_ctrl_pkg::st_add_key);
            ctl.ser_load <= (state_next == aes_ctrl_pkg::st_load);
            ctl.sub_req  <= (state_next == aes_ctrl_pkg::st_sub);
            ctl.shift_en <= (state_next == aes_ctrl_pkg::st_shift);
            ctl.mix_en   <= (state_next == aes_ctrl_pkg::st_mix);
            ctl.hold_en  <= (state_next == aes_ctrl_pkg::st_hold);
        end
    end

endmodule

//--- aes256_enc.sv
// Top level of the iterative AES-256 encryption core.
// A start pulse loads data_in; round keys are fetched from outside by
// key_addr. The ciphertext shows on data_out with a one-cycle done.
// Port blocks use FIPS byte order, byte 0 in bits 127:120.
`timescale 1ns/1ps

module aes256_enc (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                start,
    input  logic [aes_state_pkg::BLOCK_W-1:0]   data_in,
    input  logic [aes_state_pkg::BLOCK_W-1:0]   round_key,
    output logic [aes_state_pkg::BLOCK_W-1:0]   data_out,
    output logic [aes_ctrl_pkg::KEY_ADDR_W-1:0] key_addr,
    output logic                                done
);

    aes_ctrl_pkg::aes_ctl_t    ctl;
    aes_state_pkg::aes_state_t block_q;
    aes_state_pkg::aes_state_t ark_state;
    aes_state_pkg::aes_state_t shift_state;
    aes_state_pkg::aes_state_t mix_state;
    aes_state_pkg::aes_byte_t  ser_byte;
    aes_state_pkg::aes_byte_t  sub_byte;

    // Plaintext taken on the start edge, only read in round 0
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            block_q <= '0;
        else if (start)
            block_q <= aes_state_pkg::aes_state_t'(data_in);
    end

    aes_round_ctrl u_ctrl (.clk(clk), .resetn(resetn), .start(start), .ctl(ctl),
                           .key_addr(key_addr), .done(done));

    aes_add_round_key u_ark (.clk(clk), .resetn(resetn), .ctl(ctl), .block_in(block_q),
                             .shifted(shift_state), .mixed(mix_state),
                             .round_key(aes_state_pkg::aes_state_t'(round_key)),
                             .state_out(ark_state));

    aes_byte_serializer u_ser (.clk(clk), .resetn(resetn), .ctl(ctl),
                               .state_in(ark_state), .byte_out(ser_byte));

    aes_sbox_rom u_sbox (.clk(clk), .resetn(resetn), .addr(ser_byte), .sbox_out(sub_byte));

    aes_shift_rows u_shift (.clk(clk), .resetn(resetn), .ctl(ctl),
                            .byte_in(sub_byte), .state_out(shift_state));

    aes_mix_columns u_mix (.clk(clk), .resetn(resetn), .ctl(ctl),
                           .state_in(shift_state), .state_out(mix_state));

    // Key-add register holds the ciphertext until the next start
    assign data_out = ark_state;

endmodule

//--- tb_aes_assert.sv
// Protocol assertions for the AES round controller.
// Bound into aes_round_ctrl from the testbench top; fail_count lets the
// testbench include assertion failures in its final verdict.
`timescale 1ns/1ps

module tb_aes_assert (
    input  logic                   clk,
    input  logic                   resetn,
    input  aes_ctrl_pkg::aes_ctl_t ctl,
    input  logic [3:0]             round,
    input  logic                   done
);

    int unsigned fail_count = 0;

    // Data-path strobes are mutually exclusive
    a_one_strobe: assert property (@(posedge clk) disable iff (!resetn)
        $countones({ctl.ark_en, ctl.ser_load, ctl.sub_req,
                    ctl.shift_en, ctl.mix_en, ctl.hold_en}) <= 1)
    else
    begin
        fail_count++;
        $error("More than one data-path strobe high in the same cycle");
    end

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
    else
    begin
        fail_count++;
        $error("done stayed high for more than one cycle");
    end

    // Final-round flag only in round 14
    a_last_round: assert property (@(posedge clk) disable iff (!resetn)
        ctl.last_round |-> (round == aes_ctrl_pkg::NUM_ROUNDS))
    else
    begin
        fail_count++;
        $error("last_round high while round is %0d", round);
    end

endmodule

//--- tb_aes_checker.sv
// Scoreboard for the AES-256 core.
// Captures each accepted block with a snapshot of the key table, runs a
// reference AES model built on GF(2^8) arithmetic and checks data_out at
// done. Also follows key_addr and the start/done protocol.
// print_summary is called by the testbench top to give the closing line.
`timescale 1ns/1ps

module tb_aes_checker (
    input  logic         clk,
    input  logic         resetn,
    input  logic         start,
    input  logic [127:0] data_in,
    input  logic [3:0]   key_addr,
    input  logic         done,
    input  logic [127:0] data_out,
    input  logic [127:0] key_tab [0:14],
    input  logic [1:0]   test_id,
    input  int unsigned  assert_fails,
    output int unsigned  error_total
);

    // Known answer from FIPS-197 appendix C.3
    localparam logic [127:0] FIPS_CT = 128'h8ea2b7ca516745bfeafc49904b496089;

    logic [7:0]   sbox [0:255];
    logic [127:0] key_snap [0:14];
    logic [127:0] expected;
    logic [3:0]   last_addr;
    logic         busy;
    int unsigned  blocks = 0;
    int unsigned  mismatches = 0;
    int unsigned  proto_errs = 0;

    assign error_total = mismatches + proto_errs + assert_fails;

    // Shift-and-add multiply, reduced by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        int i;
        p = 8'h00;
        x = a;
        for (i = 0; i < 8; i++)
        begin
            if (b[i])
                p ^= x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Inverse as a^254, zero maps to zero
    function automatic logic [7:0] ginv(input logic [7:0] a);
        logic [7:0] r;
        logic [7:0] t;
        int i;
        r = 8'h01;
        t = a;
        for (i = 1; i < 8; i++)
        begin
            t = gmul(t, t);
            r = gmul(r, t);
        end
        return r;
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
        return (b << n) | (b >> (8 - n));
    endfunction

    // S-box = affine map of the field inverse
    initial
    begin
        logic [7:0] v;
        for (int i = 0; i < 256; i++)
        begin
            v = ginv(8'(i));
            sbox[i] = v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
        end
    end

    // Full AES-256 encryption with the snapshotted round keys
    function automatic logic [127:0] aes_model(input logic [127:0] pt);
        logic [7:0]   s [0:15];
        logic [7:0]   t [0:15];
        logic [127:0] ct;
        int r;
        int i;
        int c;
        for (i = 0; i < 16; i++)
            s[i] = pt[127-8*i -: 8] ^ key_snap[0][127-8*i -: 8];
        for (r = 1; r <= 14; r++)
        begin
            // SubBytes and ShiftRows in one pass, row i%4 rotated left
            for (i = 0; i < 16; i++)
                t[i] = sbox[s[(((i / 4) + (i % 4)) % 4) * 4 + (i % 4)]];
            for (c = 0; c < 4; c++)
            begin
                if (r == 14)
                begin
                    for (i = 0; i < 4; i++)
                        s[4*c+i] = t[4*c+i];
                end
                else
                begin
                    s[4*c]   = gmul(t[4*c], 2) ^ gmul(t[4*c+1], 3) ^ t[4*c+2] ^ t[4*c+3];
                    s[4*c+1] = t[4*c] ^ gmul(t[4*c+1], 2) ^ gmul(t[4*c+2], 3) ^ t[4*c+3];
                    s[4*c+2] = t[4*c] ^ t[4*c+1] ^ gmul(t[4*c+2], 2) ^ gmul(t[4*c+3], 3);
                    s[4*c+3] = gmul(t[4*c], 3) ^ t[4*c+1] ^ t[4*c+2] ^ gmul(t[4*c+3], 2);
                end
            end
            for (i = 0; i < 16; i++)
                s[i] ^= key_snap[r][127-8*i -: 8];
        end
        for (i = 0; i < 16; i++)
            ct[127-8*i -: 8] = s[i];
        return ct;
    endfunction

    function automatic string test_name(input logic [1:0] id);
        case (id)
            2'd0: return "fixed_vector";
            2'd1: return "random";
            2'd2: return "busy_start";
            default: return "after_reset";
        endcase
    endfunction

    task automatic check_value(input logic [127:0] exp_val);
        if (data_out !== exp_val)
        begin
            mismatches++;
            $display("Mismatch test=%s expected=%h actual=%h",
                     test_name(test_id), exp_val, data_out);
        end
    endtask

    task automatic print_summary();
        $display("Checker: %0d blocks, %0d mismatches, %0d protocol errors, %0d assertion failures",
                 blocks, mismatches, proto_errs, assert_fails);
    endtask

    always @(posedge clk)
    begin
        if (!resetn)
        begin
            busy = 1'b0;
            last_addr = 4'd0;
        end
        else
        begin
            if (done)
            begin
                if (!busy)
                begin
                    proto_errs++;
                    $display("Error in %s: done pulsed with no block in flight",
                             test_name(test_id));
                end
                else
                begin
                    blocks++;
                    check_value(expected);
                    if (test_id == 2'd0)
                        check_value(FIPS_CT);
                    if (last_addr != 4'd14)
                    begin
                        proto_errs++;
                        $display("Error in %s: key_addr only reached %0d before done",
                                 test_name(test_id), last_addr);
                    end
                end
                busy = 1'b0;
            end
            else if (busy)
            begin
                // Key address may only step up by one
                if (key_addr != last_addr)
                begin
                    if (key_addr != last_addr + 4'd1)
                    begin
                        proto_errs++;
                        $display("Error in %s: key_addr jumped from %0d to %0d",
                                 test_name(test_id), last_addr, key_addr);
                    end
                    last_addr = key_addr;
                end
            end
            else if (key_addr != 4'd0)
            begin
                proto_errs++;
                $display("Error in %s: key_addr is %0d while the core is idle",
                         test_name(test_id), key_addr);
            end
            // A start while busy is ignored by the core
            if (start && !busy)
            begin
                for (int k = 0; k < 15; k++)
                    key_snap[k] = key_tab[k];
                expected = aes_model(data_in);
                busy = 1'b1;
                last_addr = 4'd0;
            end
        end
    end

endmodule

//--- tb_aes256_enc.sv
// Top-level testbench for the AES-256 core.
// Runs the FIPS-197 vector, 200 random blocks with random round keys and
// a start pulsed while busy. Inputs change on falling edges; round_key
// follows key_addr from a table. The checker does all the comparing.
`timescale 1ns/1ps

module tb_aes256_enc;

    localparam int N_RANDOM   = 200;
    localparam int N_BLOCKS   = N_RANDOM + 2;
    localparam int MAX_CYCLES = 400 * N_BLOCKS + 100;

    // FIPS-197 C.3 key schedule, one round key per entry
    localparam logic [127:0] FIPS_KEYS [0:14] = '{
        128'h000102030405060708090a0b0c0d0e0f, 128'h101112131415161718191a1b1c1d1e1f,
        128'ha573c29fa176c498a97fce93a572c09c, 128'h1651a8cd0244beda1a5da4c10640bade,
        128'hae87dff00ff11b68a68ed5fb03fc1567, 128'h6de1f1486fa54f9275f8eb5373b8518d,
        128'hc656827fc9a799176f294cec6cd5598b, 128'h3de23a75524775e727bf9eb45407cf39,
        128'h0bdc905fc27b0948ad5245a4c1871c2f, 128'h45f5a66017b2d387300d4d33640a820a,
        128'h7ccff71cbeb4fe5413e6bbf0d261a7df, 128'hf01afafee7a82979d7a5644ab3afe640,
        128'h2541fe719bf500258813bbd55a721c0a, 128'h4e5a6699a9f24fe07e572baacdf8cdea,
        128'h24fc79ccbf0979e9371ac23c6d68de36
    };

    logic         clk;
    logic         resetn;
    logic         start;
    logic [127:0] data_in;
    logic [127:0] round_key = '0;
    logic [127:0] data_out;
    logic [3:0]   key_addr;
    logic         done;
    logic [127:0] key_tab [0:14];
    logic [1:0]   test_id;
    int unsigned  error_total;
    int unsigned  cycles = 0;

    aes256_enc uut (.clk(clk), .resetn(resetn), .start(start), .data_in(data_in),
                    .round_key(round_key), .data_out(data_out), .key_addr(key_addr),
                    .done(done));

    tb_aes_checker u_chk (.clk(clk), .resetn(resetn), .start(start), .data_in(data_in),
                          .key_addr(key_addr), .done(done), .data_out(data_out),
                          .key_tab(key_tab), .test_id(test_id),
                          .assert_fails(uut.u_ctrl.u_assert.fail_count),
                          .error_total(error_total));

    bind aes_round_ctrl tb_aes_assert u_assert (.clk(clk), .resetn(resetn), .ctl(ctl),
                                                .round(round), .done(done));

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Key lookup by the address the core drives
    always @(negedge clk)
        round_key = (key_addr <= 4'd14) ? key_tab[key_addr] : '0;

    // Overall limit on run length
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            u_chk.print_summary();
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [127:0] rand_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic load_random_keys();
        for (int k = 0; k < 15; k++)
            key_tab[k] = rand_block();
    endtask

    // One start pulse, then wait for the result
    task automatic run_block(input logic [127:0] pt);
        @(negedge clk);
        data_in = pt;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done !== 1'b1)
            @(negedge clk);
        // Test id and key table stay put until the checker has seen done
        @(negedge clk);
    endtask

    initial
    begin
        resetn = 1'b0;
        start = 1'b0;
        data_in = '0;
        test_id = 2'd3;
        for (int k = 0; k < 15; k++)
            key_tab[k] = '0;
        void'($urandom(32'h8ab35f75));
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        // Idle gap while the checker watches done and key_addr
        repeat (5) @(negedge clk);

        test_id = 2'd0;
        for (int k = 0; k < 15; k++)
            key_tab[k] = FIPS_KEYS[k];
        run_block(128'h00112233445566778899aabbccddeeff);

        test_id = 2'd1;
        for (int n = 0; n < N_RANDOM; n++)
        begin
            load_random_keys();
            run_block(rand_block());
        end

        // Second start lands mid-block and must be dropped
        test_id = 2'd2;
        load_random_keys();
        @(negedge clk);
        data_in = rand_block();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (30) @(negedge clk);
        data_in = rand_block();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done !== 1'b1)
            @(negedge clk);
        // Long enough for a stray second result to show up
        repeat (400) @(negedge clk);

        u_chk.print_summary();
        if (error_total == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- aes256_enc.f
aes_state_pkg.sv
aes_ctrl_pkg.sv
aes_sbox_rom.sv
aes_byte_serializer.sv
aes_shift_rows.sv
aes_mix_columns.sv
aes_add_round_key.sv
aes_round_ctrl.sv
aes256_enc.sv
tb_aes_assert.sv
tb_aes_checker.sv
tb_aes256_enc.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AES-256 testbench with Verilator, then grade the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aes256_enc -f aes256_enc.f -o sim_aes256

./obj_dir/sim_aes256 +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed"
    exit 1
fi
